//--- l1_cache.f
+incdir+.
l1_cache_pkg.sv
cache_way.sv
l1_cache_datapath.sv
l1_cache_control.sv
l1_cache.sv
tb_clock_gen.sv
l1_cache_props.sv
l1_cache_tb.sv

//--- Bender.yml
package:
  name: l1_cache

export_include_dirs:
  - .

sources:
  - files:
      - l1_cache_pkg.sv
      - cache_way.sv
      - l1_cache_datapath.sv
      - l1_cache_control.sv
      - l1_cache.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - l1_cache_props.sv
      - l1_cache_tb.sv

//--- l1_cache_tb.sv
`timescale 1ns/1ps
`include "l1_cache_params.svh"
`default_nettype none

module l1_cache_tb
	import l1_cache_pkg::*;
();

	localparam int clk_period = 10;
	localparam int sample_ns = 4; // one ns before the rising edge.
	localparam int worst_op_cycles = 32; // write-back plus fill, max delays.
	localparam int margin_ns = 1000;

	typedef struct {
		string name;
		logic write;
		l1_addr_u addr;
		word_t wdata;
	} op_t;

	typedef struct packed {
		logic write;
		l1_addr_u addr;
		line_t data;
	} xfer_t;

	logic clk;
	logic arst_n;
	logic mem_read;
	logic mem_write;
	l1_addr_u mem_addr;
	word_t mem_wdata;
	word_t mem_rdata;
	logic mem_resp;
	logic arb_read;
	logic arb_write;
	l1_addr_u arb_addr;
	line_t arb_wdata;
	line_t arb_rdata;
	logic arb_resp;

	op_t ops[$];
	int op_total = 0;
	xfer_t expected[$];
	xfer_t observed[$];
	line_t mem_model [logic [`ADDR_W-1:0]];
	word_t shadow [logic [`ADDR_W-1:0]]; // cpu view of memory.
	logic [TAG_W-1:0] model_tag [2][`SETS];
	logic model_valid [2][`SETS];
	logic model_dirty [2][`SETS];
	logic model_lru [`SETS];

	tb_clock_gen #(.period_ns(clk_period)) clock_gen (.clk(clk));

	l1_cache DUT (.*);

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Some tests failed");
		$fatal(1, "run stopped");
	endtask

	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (exp !== act)
			abort_run($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_line(input string name, input line_t exp, input line_t act);
		if (exp !== act)
			abort_run($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_addr(input string name, input l1_addr_u exp, input l1_addr_u act);
		if (exp.raw !== act.raw)
			abort_run($sformatf("Fail %s: expected %h, actual %h", name, exp.raw, act.raw));
	endtask

	// memory content never written depends on the byte address.
	function automatic word_t pattern_word(input logic [`ADDR_W-1:0] a);
		return {~a, a};
	endfunction

	function automatic word_t shadow_word(input logic [`ADDR_W-1:0] a);
		return shadow.exists(a) ? shadow[a] : pattern_word(a);
	endfunction

	function automatic line_t shadow_line(input logic [`ADDR_W-1:0] line_addr);
		line_t l;
		for (int i = 0; i < `WORDS_PER_LINE; i++)
			l[i] = shadow_word(line_addr + 16'(4 * i));
		return l;
	endfunction

	function automatic line_t mem_line(input logic [`ADDR_W-1:0] line_addr);
		line_t l;
		if (mem_model.exists(line_addr))
			return mem_model[line_addr];
		for (int i = 0; i < `WORDS_PER_LINE; i++)
			l[i] = pattern_word(line_addr + 16'(4 * i));
		return l;
	endfunction

	// tag, dirty and lru model; queues the memory transfers an access needs.
	function automatic void predict_access(input logic write, input l1_addr_u a,
		input word_t wdata);
		int set_i;
		int way;
		l1_addr_u line_a;
		xfer_t x;
		set_i = a.f.index;
		way = -1;
		for (int w = 0; w < 2; w++)
			if (model_valid[w][set_i] && model_tag[w][set_i] == a.f.tag)
				way = w;
		if (way < 0)
		begin
			way = model_lru[set_i];
			if (model_valid[way][set_i] && model_dirty[way][set_i])
			begin
				line_a.raw = '0;
				line_a.f.tag = model_tag[way][set_i];
				line_a.f.index = a.f.index;
				x.write = 1'b1;
				x.addr = line_a;
				x.data = shadow_line(line_a.raw);
				expected.push_back(x);
			end
			line_a = a;
			line_a.f.word = '0;
			line_a.f.byte_off = '0;
			x.write = 1'b0;
			x.addr = line_a;
			x.data = '0;
			expected.push_back(x);
			model_tag[way][set_i] = a.f.tag;
			model_valid[way][set_i] = 1'b1;
			model_dirty[way][set_i] = 1'b0;
		end
		model_lru[set_i] = (way == 0); // other way is next victim.
		if (write)
		begin
			model_dirty[way][set_i] = 1'b1;
			shadow[a.raw] = wdata;
		end
	endfunction

	function automatic void add_op(input string name, input logic write,
		input logic [`ADDR_W-1:0] addr, input word_t wdata);
		op_t op;
		op.name = name;
		op.write = write;
		op.addr.raw = addr;
		op.wdata = wdata;
		ops.push_back(op);
	endfunction

	function automatic void build_table();
		l1_addr_u a;
		add_op("cold_read", 1'b0, 16'h0094, '0);
		add_op("hit_word0", 1'b0, 16'h0090, '0);
		add_op("hit_word1", 1'b0, 16'h0094, '0);
		add_op("hit_word2", 1'b0, 16'h0098, '0);
		add_op("hit_word3", 1'b0, 16'h009c, '0);
		add_op("write_hit", 1'b1, 16'h0098, 32'hdead_beef);
		add_op("read_after_write", 1'b0, 16'h0098, '0);
		add_op("clean_fill_e", 1'b0, 16'h00a0, '0);
		add_op("clean_fill_f", 1'b0, 16'h0124, '0);
		add_op("clean_evict_g", 1'b0, 16'h01a8, '0);
		add_op("victim_miss_e", 1'b0, 16'h00ac, '0);
		add_op("fill_b", 1'b0, 16'h0110, '0);
		add_op("dirty_evict_c", 1'b1, 16'h0194, 32'h1234_5678);
		add_op("reread_a", 1'b0, 16'h0098, '0);
		add_op("lru_fill_h", 1'b0, 16'h00b0, '0);
		add_op("lru_fill_i", 1'b0, 16'h0130, '0);
		add_op("lru_touch_h", 1'b0, 16'h00b4, '0);
		add_op("lru_evict_j", 1'b0, 16'h01b0, '0);
		add_op("lru_check_h", 1'b0, 16'h00b8, '0);
		for (int i = 0; i < 200; i++)
		begin
			a.raw = '0;
			a.f.tag = TAG_W'(5 + $urandom_range(2, 0)); // three tags.
			a.f.index = IDX_W'(4 + $urandom_range(1, 0)); // two sets.
			a.f.word = OFF_W'($urandom_range(3, 0));
			add_op($sformatf("random_%0d", i), 1'($urandom_range(1, 0)), a.raw, $urandom);
		end
	endfunction

	task automatic compare_transfers(input string name);
		if (observed.size() != expected.size())
			abort_run($sformatf("%s: expected %0d memory transfers but saw %0d", name,
				expected.size(), observed.size()));
		foreach (expected[i])
		begin
			if (observed[i].write !== expected[i].write)
				abort_run($sformatf("%s: memory transfer %0d went the wrong way", name, i));
			check_addr(name, expected[i].addr, observed[i].addr);
			if (expected[i].write)
				check_line(name, expected[i].data, observed[i].data);
		end
	endtask

	task automatic run_op(input op_t op);
		word_t exp_rdata;
		exp_rdata = shadow_word(op.addr.raw);
		expected.delete();
		observed.delete();
		predict_access(op.write, op.addr, op.wdata);
		@(negedge clk);
		mem_read = !op.write;
		mem_write = op.write;
		mem_addr = op.addr;
		mem_wdata = op.wdata;
		#(sample_ns);
		while (!mem_resp)
		begin
			@(negedge clk);
			#(sample_ns);
		end
		if (!op.write)
			check_word(op.name, exp_rdata, mem_rdata);
		@(negedge clk);
		mem_read = 1'b0; // one idle cycle between requests.
		mem_write = 1'b0;
		compare_transfers(op.name);
	endtask

	// answers arb requests after 0 to 5 cycles.
	initial
	begin : memory_model
		int unsigned delay;
		xfer_t x;
		forever
		begin
			@(negedge clk);
			if (arst_n && (arb_read || arb_write))
			begin
				delay = $urandom_range(5, 0);
				repeat (delay) @(negedge clk);
				x.write = arb_write;
				x.addr = arb_addr;
				if (arb_write)
				begin
					x.data = arb_wdata;
					mem_model[arb_addr.raw] = arb_wdata;
				end
				else
				begin
					x.data = mem_line(arb_addr.raw);
					arb_rdata = x.data;
				end
				observed.push_back(x);
				arb_resp = 1'b1;
				@(negedge clk);
				arb_resp = 1'b0;
			end
		end
	end

	initial
	begin : watchdog
		wait (op_total > 0);
		#(op_total * worst_op_cycles * clk_period + margin_ns);
		abort_run("Timeout: the run exceeded its time limit");
	end

	// handshake assertions bound into the DUT.
	initial
	begin : assertion_watch
		wait (DUT.props.fail_count != 0);
		abort_run("A handshake assertion on the DUT failed");
	end

	initial
	begin : main
		void'($urandom(32'h6548));
		arst_n = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		mem_addr = '0;
		mem_wdata = '0;
		arb_rdata = '0;
		arb_resp = 1'b0;
		for (int s = 0; s < `SETS; s++)
		begin
			model_lru[s] = 1'b0;
			for (int w = 0; w < 2; w++)
			begin
				model_valid[w][s] = 1'b0;
				model_dirty[w][s] = 1'b0;
				model_tag[w][s] = '0;
			end
		end
		build_table();
		op_total = ops.size();
		repeat (8) @(negedge clk);
		arst_n = 1'b1;
		foreach (ops[i])
			run_op(ops[i]);
		@(negedge clk);
		$display("All tests passed");
		$finish;
	end

endmodule : l1_cache_tb

`default_nettype wire

//--- l1_cache_props.sv
`timescale 1ns/1ps
`default_nettype none

module l1_cache_props (
	input logic clk,
	input logic arst_n,
	input logic mem_read,
	input logic mem_write,
	input logic mem_resp,
	input logic arb_read,
	input logic arb_write,
	input logic arb_resp
);

	logic cpu_seen; // a cpu request has been made since reset.
	int fail_count = 0; // assertion failures so far.

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			cpu_seen <= 1'b0;
		else if (mem_read || mem_write)
			cpu_seen <= 1'b1;
	end

	resp_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
		mem_resp |=> !mem_resp)
	else
	begin
		$error("mem_resp held longer than one cycle");
		fail_count++;
	end

	arb_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
		!(arb_read && arb_write))
	else
	begin
		$error("arb_read and arb_write high together");
		fail_count++;
	end

	read_held: assert property (@(posedge clk) disable iff (!arst_n)
		(arb_read && !arb_resp) |=> arb_read)
	else
	begin
		$error("arb_read dropped before arb_resp");
		fail_count++;
	end

	write_held: assert property (@(posedge clk) disable iff (!arst_n)
		(arb_write && !arb_resp) |=> arb_write)
	else
	begin
		$error("arb_write dropped before arb_resp");
		fail_count++;
	end

	quiet_after_reset: assert property (@(posedge clk) disable iff (!arst_n)
		!cpu_seen |-> !(arb_read || arb_write))
	else
	begin
		$error("memory request without a cpu request");
		fail_count++;
	end

endmodule : l1_cache_props

bind l1_cache l1_cache_props props (
	.clk       (clk),
	.arst_n    (arst_n),
	.mem_read  (mem_read),
	.mem_write (mem_write),
	.mem_resp  (mem_resp),
	.arb_read  (arb_read),
	.arb_write (arb_write),
	.arb_resp  (arb_resp)
);

`default_nettype wire

//--- tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter int period_ns = 10
)
(
	output logic clk
);

	initial
	begin
		clk = 1'b0;
		forever
			#(period_ns / 2) clk = ~clk; // free-running.
	end

endmodule : tb_clock_gen

`default_nettype wire

//--- l1_cache.sv
`timescale 1ns/1ps
`default_nettype none

module l1_cache
	import l1_cache_pkg::*;
(
	input  logic     clk,
	input  logic     arst_n,
	input  logic     mem_read,
	input  logic     mem_write,
	input  l1_addr_u mem_addr,
	input  word_t    mem_wdata,
	output word_t    mem_rdata,
	output logic     mem_resp,
	output logic     arb_read,
	output logic     arb_write,
	output l1_addr_u arb_addr,
	output line_t    arb_wdata,
	input  line_t    arb_rdata,
	input  logic     arb_resp
);

	way_load_t load_w0;
	way_load_t load_w1;
	way_stat_t stat_w0;
	way_stat_t stat_w1;
	line_t merged_line;
	logic load_lru;
	logic lru_in;
	logic lru_out;
	logic write_back;
	logic wb_way_sel;
	logic hit;
	logic hit_way;
	logic dirty_w0;
	logic dirty_w1;

	l1_cache_control control (
		.clk        (clk),
		.arst_n     (arst_n),
		.mem_read   (mem_read),
		.mem_write  (mem_write),
		.hit        (hit),
		.hit_way    (hit_way),
		.lru_out    (lru_out),
		.dirty_w0   (dirty_w0),
		.dirty_w1   (dirty_w1),
		.arb_resp   (arb_resp),
		.load_w0    (load_w0),
		.load_w1    (load_w1),
		.load_lru   (load_lru),
		.lru_in     (lru_in),
		.write_back (write_back),
		.wb_way_sel (wb_way_sel),
		.mem_resp   (mem_resp),
		.arb_read   (arb_read),
		.arb_write  (arb_write)
	);

	l1_cache_datapath datapath (
		.clk         (clk),
		.arst_n      (arst_n),
		.mem_addr    (mem_addr),
		.mem_wdata   (mem_wdata),
		.stat_w0     (stat_w0),
		.stat_w1     (stat_w1),
		.load_lru    (load_lru),
		.lru_in      (lru_in),
		.write_back  (write_back),
		.wb_way_sel  (wb_way_sel),
		.hit         (hit),
		.hit_way     (hit_way),
		.lru_out     (lru_out),
		.dirty_w0    (dirty_w0),
		.dirty_w1    (dirty_w1),
		.merged_line (merged_line),
		.mem_rdata   (mem_rdata),
		.arb_addr    (arb_addr),
		.arb_wdata   (arb_wdata)
	);

	cache_way way0 (
		.clk         (clk),
		.arst_n      (arst_n),
		.index       (mem_addr.f.index),
		.tag         (mem_addr.f.tag),
		.load        (load_w0),
		.merged_line (merged_line),
		.fill_line   (arb_rdata),
		.stat        (stat_w0)
	);

	cache_way way1 (
		.clk         (clk),
		.arst_n      (arst_n),
		.index       (mem_addr.f.index),
		.tag         (mem_addr.f.tag),
		.load        (load_w1),
		.merged_line (merged_line),
		.fill_line   (arb_rdata),
		.stat        (stat_w1)
	);

endmodule : l1_cache

`default_nettype wire

//--- l1_cache_control.sv
`timescale 1ns/1ps
`default_nettype none

module l1_cache_control
	import l1_cache_pkg::*;
(
	input  logic      clk,
	input  logic      arst_n,
	input  logic      mem_read,
	input  logic      mem_write,
	input  logic      hit,
	input  logic      hit_way,
	input  logic      lru_out,
	input  logic      dirty_w0,
	input  logic      dirty_w1,
	input  logic      arb_resp,
	output way_load_t load_w0,
	output way_load_t load_w1,
	output logic      load_lru,
	output logic      lru_in,
	output logic      write_back,
	output logic      wb_way_sel,
	output logic      mem_resp,
	output logic      arb_read,
	output logic      arb_write
);

	typedef enum logic [1:0] {
		idle,
		evict, // write-back or clean fill.
		replace // fill after a write-back.
	} state_t;

	localparam way_load_t load_none = '0;

	localparam way_load_t load_fill = '{
		data: 1'b1,
		tag: 1'b1,
		valid: 1'b1,
		dirty: 1'b1,
		dirty_val: 1'b0,
		fill_sel: 1'b1
	};

	localparam way_load_t load_write = '{
		data: 1'b1,
		tag: 1'b0,
		valid: 1'b0,
		dirty: 1'b1,
		dirty_val: 1'b1,
		fill_sel: 1'b0
	};

	state_t state;
	state_t next_state;
	logic request;
	logic victim_dirty;

	assign request = mem_read | mem_write;
	assign victim_dirty = lru_out ? dirty_w1 : dirty_w0;

	always_comb
	begin
		load_w0 = load_none;
		load_w1 = load_none;
		load_lru = 1'b0;
		lru_in = 1'b0;
		write_back = 1'b0;
		wb_way_sel = 1'b0;
		mem_resp = 1'b0;
		arb_read = 1'b0;
		arb_write = 1'b0;

		case (state)
			idle:
			begin
				if (request && hit)
				begin
					mem_resp = 1'b1;
					load_lru = 1'b1;
					lru_in = ~hit_way; // other way becomes victim.
					if (mem_write)
					begin
						if (hit_way)
							load_w1 = load_write;
						else
							load_w0 = load_write;
					end
				end
			end
			evict:
			begin
				if (victim_dirty)
				begin
					write_back = 1'b1; // victim tag onto arb_addr.
					wb_way_sel = lru_out;
					arb_write = 1'b1;
				end
				else
				begin
					arb_read = 1'b1;
					if (arb_resp)
					begin
						if (lru_out)
							load_w1 = load_fill;
						else
							load_w0 = load_fill;
					end
				end
			end
			replace:
			begin
				arb_read = 1'b1;
				if (arb_resp)
				begin
					if (lru_out)
						load_w1 = load_fill;
					else
						load_w0 = load_fill;
				end
			end
			default:
			begin
			end
		endcase
	end

	always_comb
	begin
		next_state = state;
		case (state)
			idle:
				if (request && !hit)
					next_state = evict;
			evict:
				if (arb_resp)
					next_state = victim_dirty ? replace : idle;
			replace:
				if (arb_resp)
					next_state = idle;
			default:
				next_state = idle;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			state <= idle;
		else
			state <= next_state;
	end

endmodule : l1_cache_control

`default_nettype wire

//--- l1_cache_datapath.sv
`timescale 1ns/1ps
`include "l1_cache_params.svh"
`default_nettype none

module l1_cache_datapath
	import l1_cache_pkg::*;
(
	input  logic      clk,
	input  logic      arst_n,
	input  l1_addr_u  mem_addr,
	input  word_t     mem_wdata,
	input  way_stat_t stat_w0,
	input  way_stat_t stat_w1,
	input  logic      load_lru,
	input  logic      lru_in,
	input  logic      write_back,
	input  logic      wb_way_sel,
	output logic      hit,
	output logic      hit_way,
	output logic      lru_out,
	output logic      dirty_w0,
	output logic      dirty_w1,
	output line_t     merged_line,
	output word_t     mem_rdata,
	output l1_addr_u  arb_addr,
	output line_t     arb_wdata
);

	logic [`SETS-1:0] lru_q; // one bit per set, names the victim way.
	logic hit_w0;
	logic hit_w1;
	line_t hit_line;
	way_stat_t victim;

	// tag compare on both ways.
	assign hit_w0 = stat_w0.valid && (stat_w0.tag == mem_addr.f.tag);
	assign hit_w1 = stat_w1.valid && (stat_w1.tag == mem_addr.f.tag);
	assign hit = hit_w0 | hit_w1;
	assign hit_way = hit_w1; // a tag never lives in both ways.

	assign dirty_w0 = stat_w0.dirty;
	assign dirty_w1 = stat_w1.dirty;

	// pseudo-lru bits.
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			lru_q <= '0;
		else if (load_lru)
			lru_q[mem_addr.f.index] <= lru_in;
	end

	assign lru_out = lru_q[mem_addr.f.index];

	// data of the way that hit.
	assign hit_line = hit_way ? stat_w1.line : stat_w0.line;

	assign mem_rdata = hit_line[mem_addr.f.word];

	// hit line with the cpu word dropped in.
	always_comb
	begin
		merged_line = hit_line;
		merged_line[mem_addr.f.word] = mem_wdata;
	end

	// line leaving the cache on a write-back.
	assign victim = wb_way_sel ? stat_w1 : stat_w0;
	assign arb_wdata = victim.line;

	// line-aligned memory address.
	always_comb
	begin
		arb_addr = mem_addr;
		arb_addr.f.word = '0;
		arb_addr.f.byte_off = '0;
		if (write_back)
			arb_addr.f.tag = victim.tag; // same set, victim's tag.
	end

endmodule : l1_cache_datapath

`default_nettype wire

//--- cache_way.sv
`timescale 1ns/1ps
`include "l1_cache_params.svh"
`default_nettype none

module cache_way
	import l1_cache_pkg::*;
(
	input  logic             clk,
	input  logic             arst_n,
	input  logic [IDX_W-1:0] index,
	input  logic [TAG_W-1:0] tag,
	input  way_load_t        load,
	input  line_t            merged_line,
	input  line_t            fill_line,
	output way_stat_t        stat
);

	line_t data_q [`SETS];
	logic [TAG_W-1:0] tag_q [`SETS];
	logic [`SETS-1:0] valid_q;
	logic [`SETS-1:0] dirty_q;

	// line data and tags.
	always_ff @(posedge clk)
	begin
		if (load.data)
		begin
			if (load.fill_sel)
				data_q[index] <= fill_line; // refill from memory.
			else
				data_q[index] <= merged_line; // cpu write hit.
		end
		if (load.tag)
			tag_q[index] <= tag;
	end

	// state bits per set.
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			valid_q <= '0;
			dirty_q <= '0;
		end
		else
		begin
			if (load.valid)
				valid_q[index] <= 1'b1; // only a fill sets it.
			if (load.dirty)
				dirty_q[index] <= load.dirty_val;
		end
	end

	// combinational read on the index.
	always_comb
	begin
		stat.valid = valid_q[index];
		stat.dirty = dirty_q[index];
		stat.tag = tag_q[index];
		stat.line = data_q[index];
	end

endmodule : cache_way

`default_nettype wire

//--- l1_cache_pkg.sv
`include "l1_cache_params.svh"
`default_nettype none

package l1_cache_pkg;

	localparam int IDX_W = $clog2(`SETS); // set index bits.
	localparam int OFF_W = $clog2(`WORDS_PER_LINE); // word within line.
	localparam int BYTE_W = $clog2(`WORD_W / 8); // byte within word.
	localparam int TAG_W = `ADDR_W - IDX_W - OFF_W - BYTE_W;

	typedef logic [`WORD_W-1:0] word_t;

	// word 0 sits in the low bits.
	typedef word_t [`WORDS_PER_LINE-1:0] line_t;

	typedef struct packed {
		logic [TAG_W-1:0] tag;
		logic [IDX_W-1:0] index;
		logic [OFF_W-1:0] word;
		logic [BYTE_W-1:0] byte_off;
	} l1_addr_fields_t;

	typedef union packed {
		logic [`ADDR_W-1:0] raw;
		l1_addr_fields_t f;
	} l1_addr_u;

	// field enables for one way, plus the values they load.
	typedef struct packed {
		logic data;
		logic tag;
		logic valid;
		logic dirty;
		logic dirty_val; // value written when dirty is enabled.
		logic fill_sel; // memory line over cpu-merged line.
	} way_load_t;

	typedef struct packed {
		logic valid;
		logic dirty;
		logic [TAG_W-1:0] tag;
		line_t line;
	} way_stat_t;

endpackage : l1_cache_pkg

`default_nettype wire

//--- l1_cache_params.svh
`ifndef L1_CACHE_PARAMS_SVH
`define L1_CACHE_PARAMS_SVH

// byte address on the cpu side.
`define ADDR_W 16

// cpu data word.
`define WORD_W 32

// cache geometry per way.
`define SETS 8
`define WORDS_PER_LINE 4

`endif
